// File: hdl/realign_consts.svh
// realign stream source constants
// widths and sizes shared by the RTL and the testbench
`ifndef REALIGN_CONSTS_SVH
`define REALIGN_CONSTS_SVH

// stream data width in bits
`define REALIGN_DW 32

// bytes per stream word
`define REALIGN_BW 4

// byte address width, sized so that the word part indexes the whole memory
`define REALIGN_AW 12

// depth of the local word memory
`define REALIGN_MEM_WORDS 1024

// width of the per-transfer word count
`define REALIGN_LEN_W 8

`endif

// File: hdl/realign_pkg.sv
// realign package
// packed types shared by the realigning stream source and its testbench
`default_nettype none

`include "realign_consts.svh"

package realign_pkg;

  // word address into the local memory
  typedef logic [`REALIGN_AW-$clog2(`REALIGN_BW)-1:0] realign_waddr_t;

  // one transfer as programmed by the host side
  typedef struct packed {
    logic [`REALIGN_AW-1:0]    base_addr;
    logic [`REALIGN_LEN_W-1:0] n_words;
  } realign_cfg_t;

  // control attached to each memory read
  typedef struct packed {
    logic                   realign;
    logic                   first;
    logic                   last;
    logic [`REALIGN_BW-1:0] strb;
  } realign_ctrl_t;

  // stream beat, ready travels on its own wire
  typedef struct packed {
    logic                   valid;
    logic [`REALIGN_DW-1:0] data;
  } realign_word_t;

  // preload write port of the word memory
  typedef struct packed {
    logic                   we;
    realign_waddr_t         addr;
    logic [`REALIGN_DW-1:0] data;
  } realign_mem_wr_t;

endpackage

`default_nettype wire

// File: hdl/realign_addrgen.sv
// realign address generator
// walks the aligned words covering a byte range and tags each read
// with first/last flags and the byte strobes of the misaligned ends
`default_nettype none

`include "realign_consts.svh"

module realign_addrgen
  import realign_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           start_i,
  input  realign_cfg_t   cfg_i,
  output logic           busy_o,
  output logic           rd_valid_o,
  output realign_waddr_t rd_addr_o,
  output realign_ctrl_t  ctrl_o,
  input  logic           rd_ready_i
);

  logic                              busy_q;
  realign_waddr_t                    base_q;
  logic [$clog2(`REALIGN_BW)-1:0]    off_q;
  logic [`REALIGN_LEN_W-1:0]         last_idx_q;
  logic [`REALIGN_LEN_W-1:0]         rd_cnt_q;
  logic                              realign;
  logic                              first;
  logic                              last;
  logic                              rd_done;
  logic [`REALIGN_BW-1:0]            head_strb;

  // a read completes when the shifter takes it
  assign rd_done = busy_q & rd_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      base_q     <= '0;
      off_q      <= '0;
      last_idx_q <= '0;
      rd_cnt_q   <= '0;
    end else if (start_i && !busy_q) begin
      busy_q   <= 1'b1;
      base_q   <= cfg_i.base_addr[`REALIGN_AW-1:$clog2(`REALIGN_BW)];
      off_q    <= cfg_i.base_addr[$clog2(`REALIGN_BW)-1:0];
      rd_cnt_q <= '0;
      // a misaligned range touches one extra word
      if (cfg_i.base_addr[$clog2(`REALIGN_BW)-1:0] != '0) begin
        last_idx_q <= cfg_i.n_words;
      end else begin
        last_idx_q <= cfg_i.n_words - 1'b1;
      end
    end else if (rd_done) begin
      if (last) begin
        busy_q <= 1'b0;
      end else begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
      end
    end
  end

  assign realign = (off_q != '0);
  assign first   = (rd_cnt_q == '0);
  assign last    = (rd_cnt_q == last_idx_q);

  // bytes off..BW-1 of the head word belong to the transfer
  assign head_strb = {`REALIGN_BW{1'b1}} << off_q;

  always_comb begin
    ctrl_o.realign = realign;
    ctrl_o.first   = first;
    ctrl_o.last    = last;
    ctrl_o.strb    = '1;
    if (realign) begin
      if (first) begin
        ctrl_o.strb = head_strb;
      end else if (last) begin
        // tail word keeps only the bytes below the offset
        ctrl_o.strb = ~head_strb;
      end
    end
  end

  assign busy_o     = busy_q;
  assign rd_valid_o = busy_q;
  assign rd_addr_o  = base_q + realign_waddr_t'(rd_cnt_q);

endmodule

`default_nettype wire

// File: hdl/realign_word_mem.sv
// realign word memory
// local storage with a preload write port and a zero-latency read stream
`default_nettype none

`include "realign_consts.svh"

module realign_word_mem
  import realign_pkg::*;
(
  input  logic            clk_i,
  input  realign_mem_wr_t mem_wr_i,
  input  logic            rd_valid_i,
  input  realign_waddr_t  rd_addr_i,
  output realign_word_t   rd_word_o
);

  logic [`REALIGN_DW-1:0] mem_q [`REALIGN_MEM_WORDS];
  logic [`REALIGN_DW-1:0] rd_data;

  // preload writes land on the clock edge
  always_ff @(posedge clk_i) begin
    if (mem_wr_i.we) begin
      mem_q[mem_wr_i.addr] <= mem_wr_i.data;
    end
  end

  // asynchronous read, so the data comes back in the request cycle
  // and the realigner can treat the read and its control as one beat
  assign rd_data = mem_q[rd_addr_i];

  // the beat is valid exactly when a read is requested
  assign rd_word_o.valid = rd_valid_i;
  assign rd_word_o.data  = rd_data;

endmodule

`default_nettype wire

// File: hdl/realign_shifter.sv
// realign shifter
// merges each read word with the previous one, rotated by the byte
// count of the first word's strobe, to emit byte-aligned output words
`default_nettype none

`include "realign_consts.svh"

module realign_shifter
  import realign_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  realign_ctrl_t ctrl_i,
  input  realign_word_t in_i,
  output logic          in_ready_o,
  output realign_word_t out_o,
  input  logic          out_ready_i
);

  logic [$clog2(`REALIGN_BW):0]     rot_d;
  logic [$clog2(`REALIGN_BW):0]     rot_q;
  logic [$clog2(`REALIGN_BW):0]     rot_inv;
  logic [$clog2(`REALIGN_DW):0]     sh_up;
  logic [$clog2(`REALIGN_DW):0]     sh_dn;
  logic [`REALIGN_DW-1:0]           prev_q;
  logic [`REALIGN_DW-1:0]           merged;
  logic                             in_hs;

  assign in_hs = in_i.valid & in_ready_o;

  // rotation is the number of valid bytes in the head word
  always_comb begin
    rot_d = '0;
    for (int i = 0; i < `REALIGN_BW; i++) begin
      rot_d = rot_d + ($bits(rot_d))'(ctrl_i.strb[i]);
    end
  end

  // captured once per transfer from a misaligned head word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rot_q <= '0;
    end else if (in_hs && ctrl_i.first && ctrl_i.realign) begin
      rot_q <= rot_d;
    end
  end

  // previous accepted word feeds the low bytes of the next merge
  always_ff @(posedge clk_i) begin
    if (in_hs) begin
      prev_q <= in_i.data;
    end
  end

  assign rot_inv = ($bits(rot_inv))'(`REALIGN_BW) - rot_q;

  // byte counts to bit shifts
  assign sh_up = {rot_q, 3'b000};
  assign sh_dn = {rot_inv, 3'b000};

  // current word fills the upper bytes and the previous word's tail the lower ones
  assign merged = (in_i.data << sh_up) | (prev_q >> sh_dn);

  always_comb begin
    out_o.valid = in_i.valid;
    out_o.data  = in_i.data;
    in_ready_o  = out_ready_i;
    if (ctrl_i.realign) begin
      // the head word only primes prev_q and produces no output
      out_o.valid = in_i.valid & ~ctrl_i.first;
      out_o.data  = merged;
      in_ready_o  = out_ready_i | ctrl_i.first;
    end
  end

endmodule

`default_nettype wire

// File: hdl/realign_source_top.sv
// realign source top
// address generator, word memory and realigner forming a byte-aligned stream
`default_nettype none

module realign_source_top
  import realign_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  realign_cfg_t    cfg_i,
  output logic            busy_o,
  input  realign_mem_wr_t mem_wr_i,
  output realign_word_t   out_o,
  input  logic            out_ready_i
);

  logic           rd_valid;
  logic           rd_ready;
  realign_waddr_t rd_addr;
  realign_ctrl_t  rd_ctrl;
  realign_word_t  rd_word;

  // read side, stalled directly by the realigner's ready
  realign_addrgen u_addrgen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .cfg_i      (cfg_i),
    .busy_o     (busy_o),
    .rd_valid_o (rd_valid),
    .rd_addr_o  (rd_addr),
    .ctrl_o     (rd_ctrl),
    .rd_ready_i (rd_ready)
  );

  realign_word_mem u_word_mem (
    .clk_i      (clk_i),
    .mem_wr_i   (mem_wr_i),
    .rd_valid_i (rd_valid),
    .rd_addr_i  (rd_addr),
    .rd_word_o  (rd_word)
  );

  // control and data of one read arrive together, zero latency
  realign_shifter u_shifter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctrl_i      (rd_ctrl),
    .in_i        (rd_word),
    .in_ready_o  (rd_ready),
    .out_o       (out_o),
    .out_ready_i (out_ready_i)
  );

endmodule

`default_nettype wire

// File: bench/realign_asserts.sv
// realign stream source checks
// concurrent assertions on the output handshake and busy, bound into the top level
`default_nettype none

module realign_asserts
  import realign_pkg::*;
(
  input logic          clk_i,
  input logic          rst_ni,
  input logic          busy_i,
  input realign_word_t out_i,
  input logic          out_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // a stalled beat keeps both its valid and its data
  out_stable_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_i.valid && !out_ready_i) |=> (out_i.valid && $stable(out_i.data))
  ) else $error("output beat changed while stalled");

  // first cycle out of reset is idle
  reset_idle_a : assert property (
    @(posedge clk_i)
    $rose(rst_ni) |-> (!busy_i && !out_i.valid)
  ) else $error("busy or output valid set right after reset release");

  // the stream only runs inside a transfer
  valid_in_busy_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_i.valid |-> busy_i
  ) else $error("output valid while no transfer is running");

endmodule

bind realign_source_top realign_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .busy_i      (busy_o),
  .out_i       (out_o),
  .out_ready_i (out_ready_i)
);

`default_nettype wire

// File: bench/realign_tb.sv
// realign stream source testbench
// preloads the word memory, runs aligned and misaligned transfers and checks the stream
`default_nettype none

`include "realign_consts.svh"

module realign_tb
  import realign_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_xfers     = 12;
  localparam int preload_words = 128;

  // 0 aligned, 1..6 offsets 1..3 short and long, 7 under stalls,
  // 8..10 back to back, 11 running while a second start arrives
  localparam logic [`REALIGN_AW-1:0] base_list [num_xfers] = '{
    12'h010, 12'h021, 12'h031, 12'h052, 12'h062, 12'h083,
    12'h093, 12'h0c2, 12'h113, 12'h120, 12'h132, 12'h151
  };
  localparam logic [`REALIGN_LEN_W-1:0] len_list [num_xfers] = '{
    8'd5, 8'd1, 8'd6, 8'd1, 8'd6, 8'd1, 8'd6, 8'd16, 8'd4, 8'd3, 8'd5, 8'd8
  };

  logic            clk;
  logic            rst_n;
  logic            start;
  realign_cfg_t    cfg;
  logic            busy;
  realign_mem_wr_t mem_wr;
  realign_word_t   out_beat;
  logic            out_ready;
  logic            rand_ready;
  logic            counting;

  logic [7:0]             ref_bytes [preload_words*`REALIGN_BW];
  logic [`REALIGN_DW-1:0] exp_q [$];
  logic [`REALIGN_DW-1:0] exp_data;
  int unsigned            beat_cnt = 0;
  int unsigned            cycle_cnt = 0;
  int unsigned            timeout_limit;

  realign_source_top dut0 (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .start_i     (start),
    .cfg_i       (cfg),
    .busy_o      (busy),
    .mem_wr_i    (mem_wr),
    .out_o       (out_beat),
    .out_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // aligned reads of one transfer with one extra when it starts mid-word
  function automatic int unsigned reads_of(int idx);
    int unsigned n;
    n = len_list[idx];
    if (base_list[idx] % `REALIGN_BW != 0) begin
      n = n + 1;
    end
    return n;
  endfunction

  function automatic int unsigned total_words();
    int unsigned sum;
    sum = 0;
    for (int i = 0; i < num_xfers; i++) begin
      sum = sum + len_list[i];
    end
    return sum;
  endfunction

  // four consecutive bytes from the reference copy with the lowest address in the low byte
  function automatic logic [`REALIGN_DW-1:0] expected_word(int addr);
    logic [`REALIGN_DW-1:0] w;
    for (int b = 0; b < `REALIGN_BW; b++) begin
      w[8*b +: 8] = ref_bytes[addr + b];
    end
    return w;
  endfunction

  task automatic preload_memory();
    logic [`REALIGN_DW-1:0] word;
    for (int w = 0; w < preload_words; w++) begin
      word        = $urandom();
      mem_wr.we   = 1'b1;
      mem_wr.addr = realign_waddr_t'(w);
      mem_wr.data = word;
      for (int b = 0; b < `REALIGN_BW; b++) begin
        ref_bytes[w*`REALIGN_BW + b] = word[8*b +: 8];
      end
      @(negedge clk);
    end
    mem_wr = '0;
  endtask

  // one start pulse that also queues the words it must produce
  task automatic start_transfer(int idx);
    start         = 1'b1;
    cfg.base_addr = base_list[idx];
    cfg.n_words   = len_list[idx];
    for (int k = 0; k < int'(len_list[idx]); k++) begin
      exp_q.push_back(expected_word(int'(base_list[idx]) + k*`REALIGN_BW));
    end
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_idle();
    while (busy) begin
      @(negedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("busy_o fell at %0d ns with %0d output words still pending",
               $time, exp_q.size());
      $display("RESULT: FAIL");
      $fatal(1, "transfer ended before all words were streamed");
    end
  endtask

  // ready is high unless a stall phase randomizes it
  initial begin
    out_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (rand_ready) begin
        out_ready = 1'($urandom());
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // compare every accepted beat with the next expected word
  always @(posedge clk) begin
    if (rst_n && out_beat.valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("output beat at %0d ns arrived with no transfer pending", $time);
        $display("RESULT: FAIL");
        $fatal(1, "unexpected output beat");
      end else begin
        exp_data = exp_q.pop_front();
        if (out_beat.data !== exp_data) begin
          $display("error at %0d ns: dut0.out_o.data = %08h, expected %08h",
                   $time, out_beat.data, exp_data);
          $display("RESULT: FAIL");
          $fatal(1, "output data mismatch");
        end
        beat_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    if (counting) begin
      cycle_cnt++;
      if (cycle_cnt > timeout_limit) begin
        $display("timeout, no end of test after %0d cycles", timeout_limit);
        $display("RESULT: FAIL");
        $fatal(1, "simulation timed out");
      end
    end
  end

  initial begin
    void'($urandom(32'hce12a4dd));
    rst_n      = 1'b0;
    start      = 1'b0;
    cfg        = '0;
    mem_wr     = '0;
    rand_ready = 1'b0;
    counting   = 1'b0;
    timeout_limit = 200;
    for (int i = 0; i < num_xfers; i++) begin
      timeout_limit = timeout_limit + 4*reads_of(i);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    preload_memory();
    counting = 1'b1;
    // aligned pass-through and then each offset with one and six words
    for (int i = 0; i < 7; i++) begin
      start_transfer(i);
      wait_idle();
      repeat (2) @(negedge clk);
    end
    // misaligned transfer under random back-pressure
    rand_ready = 1'b1;
    start_transfer(7);
    wait_idle();
    rand_ready = 1'b0;
    repeat (2) @(negedge clk);
    // each start on the first idle cycle with a new offset every time
    for (int i = 8; i < 11; i++) begin
      start_transfer(i);
      wait_idle();
    end
    repeat (2) @(negedge clk);
    // a second start in the middle of a transfer must be dropped
    start_transfer(11);
    @(negedge clk);
    if (!busy) begin
      $display("busy_o low at %0d ns in the middle of a transfer", $time);
      $display("RESULT: FAIL");
      $fatal(1, "transfer ended too early");
    end
    start         = 1'b1;
    cfg.base_addr = 12'h1a0;
    cfg.n_words   = 8'd2;
    @(negedge clk);
    start = 1'b0;
    wait_idle();
    repeat (4) @(negedge clk);
    if (beat_cnt != total_words()) begin
      $display("error at %0d ns: output beat count = %0d, expected %0d",
               $time, beat_cnt, total_words());
      $display("RESULT: FAIL");
      $fatal(1, "wrong number of output beats");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/realign_pkg.sv
hdl/realign_addrgen.sv
hdl/realign_word_mem.sv
hdl/realign_shifter.sv
hdl/realign_source_top.sv
bench/realign_asserts.sv
bench/realign_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the realign testbench with Verilator and run it, the exit status gives pass or fail
cd "$(dirname "$0")" &&
  verilator --binary --assert --timescale 1ns/1ps --top-module realign_tb \
    -f verilog.f -o realign_sim &&
  ./obj_dir/realign_sim ||
  exit 1
